/* rtl/ex_pkg.sv */
// shared widths, field types and code points of the integer execute stage
// imported by every unit of the lane, the queue and the bus driver
`default_nettype none

package ex_pkg;

    ////////////////////////////////////////
    // widths
    ////////////////////////////////////////
    localparam int XLEN        = 32;
    localparam int TAG_W       = 5;
    localparam int SHAMT_W     = 5;
    localparam int QUEUE_DEPTH = 4;
    // queue pointer and occupancy widths
    localparam int QPTR_W      = $clog2(QUEUE_DEPTH);
    localparam int QCNT_W      = $clog2(QUEUE_DEPTH + 1);

    typedef logic [XLEN-1:0]  xlen_t;
    typedef logic [TAG_W-1:0] rob_tag_t;
    typedef logic [31:0]      inst_t;
    typedef logic [3:0]       alu_func_t;
    typedef logic [1:0]       opa_sel_t;
    typedef logic [2:0]       opb_sel_t;
    typedef logic [2:0]       br_func_t;

    ////////////////////////////////////////
    // alu functions
    ////////////////////////////////////////
    localparam alu_func_t ALU_ADD  = 4'h0;
    localparam alu_func_t ALU_SUB  = 4'h1;
    localparam alu_func_t ALU_AND  = 4'h2;
    localparam alu_func_t ALU_OR   = 4'h3;
    localparam alu_func_t ALU_XOR  = 4'h4;
    localparam alu_func_t ALU_SLT  = 4'h5;
    localparam alu_func_t ALU_SLTU = 4'h6;
    localparam alu_func_t ALU_SLL  = 4'h7;
    localparam alu_func_t ALU_SRL  = 4'h8;
    localparam alu_func_t ALU_SRA  = 4'h9;

    // operand a sources
    localparam opa_sel_t OPA_IS_RS1  = 2'd0;
    localparam opa_sel_t OPA_IS_NPC  = 2'd1;
    localparam opa_sel_t OPA_IS_PC   = 2'd2;
    localparam opa_sel_t OPA_IS_ZERO = 2'd3;

    // operand b sources
    localparam opb_sel_t OPB_IS_RS2   = 3'd0;
    localparam opb_sel_t OPB_IS_I_IMM = 3'd1;
    localparam opb_sel_t OPB_IS_S_IMM = 3'd2;
    localparam opb_sel_t OPB_IS_B_IMM = 3'd3;
    localparam opb_sel_t OPB_IS_U_IMM = 3'd4;
    localparam opb_sel_t OPB_IS_J_IMM = 3'd5;

    // branch funct3, straight from the RV32I encoding
    localparam br_func_t BR_BEQ  = 3'b000;
    localparam br_func_t BR_BNE  = 3'b001;
    localparam br_func_t BR_BLT  = 3'b100;
    localparam br_func_t BR_BGE  = 3'b101;
    localparam br_func_t BR_BLTU = 3'b110;
    localparam br_func_t BR_BGEU = 3'b111;

endpackage

`default_nettype wire

/* rtl/ex_result_if.sv */
// completion record link between execute units
// source offers valid plus the record, sink answers with pop
`timescale 1ns/1ps
`default_nettype none

interface ex_result_if;
    import ex_pkg::*;

    // record offered by the source
    logic     valid;
    rob_tag_t tag;
    xlen_t    value;
    logic     take_branch;
    // sink takes the record on an edge with valid and pop high
    logic     pop;

    modport source (
        output valid,
        output tag,
        output value,
        output take_branch,
        input  pop
    );

    modport sink (
        input  valid,
        input  tag,
        input  value,
        input  take_branch,
        output pop
    );

endinterface

`default_nettype wire

/* rtl/alu_lane.sv */
// single integer alu lane of the execute stage
// operand muxing, immediate decode, alu and branch resolve, all combinational
// the completion record follows the issue inputs in the same cycle
`timescale 1ns/1ps
`default_nettype none

module alu_lane (
    input  logic              issue_valid,
    input  ex_pkg::rob_tag_t  rob_tag,
    input  ex_pkg::alu_func_t alu_func,
    input  ex_pkg::opa_sel_t  opa_select,
    input  ex_pkg::opb_sel_t  opb_select,
    input  ex_pkg::xlen_t     rs1,
    input  ex_pkg::xlen_t     rs2,
    input  ex_pkg::xlen_t     pc,
    input  ex_pkg::xlen_t     npc,
    input  ex_pkg::inst_t     inst,
    input  logic              cond_branch,
    input  logic              uncond_branch,
    ex_result_if.source       result
);
    import ex_pkg::*;

    xlen_t               opa;
    xlen_t               opb;
    xlen_t               alu_out;
    logic [SHAMT_W-1:0]  shamt;
    br_func_t            br_func;
    logic                br_taken;

    ////////////////////////////////////////
    // operand selection
    ////////////////////////////////////////
    always_comb begin
        case (opa_select)
            OPA_IS_RS1:  opa = rs1;
            OPA_IS_NPC:  opa = npc;
            OPA_IS_PC:   opa = pc;
            OPA_IS_ZERO: opa = '0;
            default:     opa = '0;
        endcase
    end

    // immediates sign-extended from bit 31 per RV32I layouts
    always_comb begin
        case (opb_select)
            OPB_IS_RS2:   opb = rs2;
            OPB_IS_I_IMM: opb = {{20{inst[31]}}, inst[31:20]};
            OPB_IS_S_IMM: opb = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            OPB_IS_B_IMM: opb = {{19{inst[31]}}, inst[31], inst[7], inst[30:25],
                                 inst[11:8], 1'b0};
            OPB_IS_U_IMM: opb = {inst[31:12], 12'b0};
            OPB_IS_J_IMM: opb = {{11{inst[31]}}, inst[31], inst[19:12], inst[20],
                                 inst[30:21], 1'b0};
            // unknown select reads as zero
            default:      opb = '0;
        endcase
    end

    ////////////////////////////////////////
    // alu
    ////////////////////////////////////////
    assign shamt = opb[SHAMT_W-1:0];

    always_comb begin
        case (alu_func)
            ALU_ADD:  alu_out = opa + opb;
            ALU_SUB:  alu_out = opa - opb;
            ALU_AND:  alu_out = opa & opb;
            ALU_OR:   alu_out = opa | opb;
            ALU_XOR:  alu_out = opa ^ opb;
            ALU_SLT:  alu_out = {{(XLEN-1){1'b0}}, $signed(opa) < $signed(opb)};
            ALU_SLTU: alu_out = {{(XLEN-1){1'b0}}, opa < opb};
            ALU_SLL:  alu_out = opa << shamt;
            ALU_SRL:  alu_out = opa >> shamt;
            // sign bit fills from the left
            ALU_SRA:  alu_out = xlen_t'($signed(opa) >>> shamt);
            default:  alu_out = '0;
        endcase
    end

    ////////////////////////////////////////
    // branch condition
    ////////////////////////////////////////
    // always compares the raw register values, not the muxed operands
    assign br_func = inst[14:12];

    always_comb begin
        case (br_func)
            BR_BEQ:  br_taken = (rs1 == rs2);
            BR_BNE:  br_taken = (rs1 != rs2);
            BR_BLT:  br_taken = ($signed(rs1) <  $signed(rs2));
            BR_BGE:  br_taken = ($signed(rs1) >= $signed(rs2));
            BR_BLTU: br_taken = (rs1 <  rs2);
            BR_BGEU: br_taken = (rs1 >= rs2);
            default: br_taken = 1'b0;
        endcase
    end

    // completion record
    assign result.valid       = issue_valid;
    assign result.tag         = rob_tag;
    assign result.take_branch = uncond_branch | (cond_branch & br_taken);
    // fall-through branch hands back npc as the next fetch address
    assign result.value       = (cond_branch && !br_taken) ? npc : alu_out;

endmodule

`default_nettype wire

/* rtl/result_fifo.sv */
// circular queue of completion records between the alu lane and the cdb
// writes every valid record, exposes the head, flags one slot left
`timescale 1ns/1ps
`default_nettype none

module result_fifo (
    input  logic         clk,
    input  logic         rst,
    ex_result_if.sink    wr,
    ex_result_if.source  rd,
    output logic         almost_full
);
    import ex_pkg::*;

    // record storage
    rob_tag_t mem_tag   [QUEUE_DEPTH];
    xlen_t    mem_value [QUEUE_DEPTH];
    logic     mem_br    [QUEUE_DEPTH];

    logic [QPTR_W-1:0] wr_ptr;
    logic [QPTR_W-1:0] rd_ptr;
    logic [QCNT_W-1:0] count;
    logic              push;
    logic              pull;

    // the queue takes every valid record
    assign wr.pop = wr.valid;
    assign push   = wr.valid;
    assign pull   = rd.valid & rd.pop;

    always_ff @(posedge clk) begin
        if (push) begin
            mem_tag[wr_ptr]   <= wr.tag;
            mem_value[wr_ptr] <= wr.value;
            mem_br[wr_ptr]    <= wr.take_branch;
        end
    end

    ////////////////////////////////////////
    // pointers and occupancy
    ////////////////////////////////////////
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == QPTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pull) begin
                rd_ptr <= (rd_ptr == QPTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // write and pop together leave count alone
            if (push && !pull) begin
                count <= count + 1'b1;
            end else if (pull && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // head record
    assign rd.valid       = (count != '0);
    assign rd.tag         = mem_tag[rd_ptr];
    assign rd.value       = mem_value[rd_ptr];
    assign rd.take_branch = mem_br[rd_ptr];

    // one free slot left for the record in flight
    assign almost_full = (count >= QCNT_W'(QUEUE_DEPTH - 1));

endmodule

`default_nettype wire

/* rtl/cdb_driver.sv */
// common data bus driver
// pops the queue head whenever the bus is free and registers it onto the cdb
// cdb_valid lasts one cycle per record
`timescale 1ns/1ps
`default_nettype none

module cdb_driver (
    input  logic             clk,
    input  logic             rst,
    input  logic             cdb_busy,
    ex_result_if.sink        head,
    output logic             cdb_valid,
    output ex_pkg::rob_tag_t cdb_tag,
    output ex_pkg::xlen_t    cdb_value,
    output logic             cdb_take_branch
);
    import ex_pkg::*;

    logic pop;

    // something queued and nobody else on the bus
    assign pop      = head.valid & ~cdb_busy;
    assign head.pop = pop;

    ////////////////////////////////////////
    // bus registers
    ////////////////////////////////////////
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cdb_valid       <= 1'b0;
            cdb_tag         <= '0;
            cdb_value       <= '0;
            cdb_take_branch <= 1'b0;
        end else begin
            // drop valid on any cycle without a pop
            cdb_valid <= pop;
            if (pop) begin
                cdb_tag         <= head.tag;
                cdb_value       <= head.value;
                cdb_take_branch <= head.take_branch;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/ex_stage.sv */
// integer execute stage top, one alu lane feeding a completion queue
// issue side: issue_valid with alu_busy back-pressure
// bus side: registered cdb broadcast held off by cdb_busy
`timescale 1ns/1ps
`default_nettype none

module ex_stage (
    input  logic              clk,
    input  logic              rst,
    input  logic              issue_valid,
    input  ex_pkg::rob_tag_t  rob_tag,
    input  ex_pkg::alu_func_t alu_func,
    input  ex_pkg::opa_sel_t  opa_select,
    input  ex_pkg::opb_sel_t  opb_select,
    input  ex_pkg::xlen_t     rs1,
    input  ex_pkg::xlen_t     rs2,
    input  ex_pkg::xlen_t     pc,
    input  ex_pkg::xlen_t     npc,
    input  ex_pkg::inst_t     inst,
    input  logic              cond_branch,
    input  logic              uncond_branch,
    input  logic              cdb_busy,
    output logic              alu_busy,
    output logic              cdb_valid,
    output ex_pkg::rob_tag_t  cdb_tag,
    output ex_pkg::xlen_t     cdb_value,
    output logic              cdb_take_branch
);

    // lane to queue, queue to bus driver
    ex_result_if lane_q ();
    ex_result_if bcast_q ();

    ////////////////////////////////////////
    // datapath
    ////////////////////////////////////////
    alu_lane u_lane (
        .issue_valid   (issue_valid),
        .rob_tag       (rob_tag),
        .alu_func      (alu_func),
        .opa_select    (opa_select),
        .opb_select    (opb_select),
        .rs1           (rs1),
        .rs2           (rs2),
        .pc            (pc),
        .npc           (npc),
        .inst          (inst),
        .cond_branch   (cond_branch),
        .uncond_branch (uncond_branch),
        .result        (lane_q.source)
    );

    // almost_full doubles as the issue stall
    result_fifo u_queue (
        .clk         (clk),
        .rst         (rst),
        .wr          (lane_q.sink),
        .rd          (bcast_q.source),
        .almost_full (alu_busy)
    );

    cdb_driver u_cdb (
        .clk             (clk),
        .rst             (rst),
        .cdb_busy        (cdb_busy),
        .head            (bcast_q.sink),
        .cdb_valid       (cdb_valid),
        .cdb_tag         (cdb_tag),
        .cdb_value       (cdb_value),
        .cdb_take_branch (cdb_take_branch)
    );

endmodule

`default_nettype wire

/* dv/ex_stage_assertions.sv */
// handshake checks for the execute stage, bound into every ex_stage instance
// covers issue back-pressure, cdb hold-off, reset and known bus fields
`timescale 1ns/1ps
`default_nettype none

module ex_stage_assertions (
    input logic             clk,
    input logic             rst,
    input logic             issue_valid,
    input logic             alu_busy,
    input logic             cdb_busy,
    input logic             cdb_valid,
    input ex_pkg::rob_tag_t cdb_tag,
    input ex_pkg::xlen_t    cdb_value,
    input logic             cdb_take_branch
);

    ////////////////////////////////////////
    // issue side
    ////////////////////////////////////////
    no_issue_when_busy: assert property (@(posedge clk) disable iff (rst)
        !(issue_valid && alu_busy))
        else $error("issue_valid raised while alu_busy is high");

    // bus side, busy blocks the broadcast in the next cycle
    busy_blocks_bus: assert property (@(posedge clk) disable iff (rst)
        cdb_busy |=> !cdb_valid)
        else $error("cdb_valid high in the cycle after cdb_busy");

    reset_clears_bus: assert property (@(posedge clk)
        rst |-> !cdb_valid)
        else $error("cdb_valid high during reset");

    // no x or z on a broadcast record
    bus_fields_known: assert property (@(posedge clk) disable iff (rst)
        cdb_valid |-> !$isunknown({cdb_tag, cdb_value, cdb_take_branch}))
        else $error("unknown bits on the CDB while cdb_valid is high");

endmodule

bind ex_stage ex_stage_assertions u_assertions (
    .clk             (clk),
    .rst             (rst),
    .issue_valid     (issue_valid),
    .alu_busy        (alu_busy),
    .cdb_busy        (cdb_busy),
    .cdb_valid       (cdb_valid),
    .cdb_tag         (cdb_tag),
    .cdb_value       (cdb_value),
    .cdb_take_branch (cdb_take_branch)
);

`default_nettype wire

/* dv/tb_ex_stage.sv */
// testbench for the execute stage top level
// issues instructions from the vector file, throttles the CDB at random
// and checks every broadcast in issue order against the expected record
`timescale 1ns/1ps
`default_nettype none

module tb_ex_stage;
    import ex_pkg::*;

    logic      clk;
    logic      rst;
    logic      issue_valid;
    rob_tag_t  rob_tag;
    alu_func_t alu_func;
    opa_sel_t  opa_select;
    opb_sel_t  opb_select;
    xlen_t     rs1;
    xlen_t     rs2;
    xlen_t     pc;
    xlen_t     npc;
    inst_t     inst;
    logic      cond_branch;
    logic      uncond_branch;
    logic      cdb_busy;
    logic      alu_busy;
    logic      cdb_valid;
    rob_tag_t  cdb_tag;
    xlen_t     cdb_value;
    logic      cdb_take_branch;

    logic        busy_mode;
    int          busy_cycle;
    logic [31:0] vec [64][13];
    logic [31:0] exp_tag [$];
    logic [31:0] exp_value [$];
    logic [31:0] exp_br [$];
    // expected queue occupancy now and after the coming edge
    int          occ;
    int          occ_next;
    int          n_vec;
    int          n_seen;
    int          n_stalls;
    int          n_checks;
    int          n_errors;

    ex_stage i_dut (.*);

    always #10 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        n_checks++;
        if (actual !== expected) begin
            n_errors++;
            $display("Mismatch at time %0t: %s expected %h actual %h",
                     $time, name, expected, actual);
        end
    endtask

    ////////////////////////////////////////
    // vector file
    ////////////////////////////////////////
    task automatic read_vectors();
        int          fd;
        int          rc;
        int          k;
        string       line;
        logic [31:0] f [13];
        fd = $fopen("dv/ex_input_vectors.txt", "r");
        if (fd == 0) begin
            n_errors++;
            $display("could not open the vector file dv/ex_input_vectors.txt");
            return;
        end
        while (!$feof(fd)) begin
            rc = $fgets(line, fd);
            // lines starting with # are column notes
            if (rc > 0 && line.getc(0) != "#") begin
                rc = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                             f[0], f[1], f[2], f[3], f[4], f[5], f[6],
                             f[7], f[8], f[9], f[10], f[11], f[12]);
                if (rc == 13 && n_vec < 64) begin
                    for (k = 0; k < 13; k++) begin
                        vec[n_vec][k] = f[k];
                    end
                    n_vec++;
                end else if (rc > 0) begin
                    n_errors++;
                    $display("vector line could not be used: %s", line);
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic drive_vector(input int i);
        issue_valid   <= 1'b1;
        rob_tag       <= rob_tag_t'(vec[i][0]);
        alu_func      <= alu_func_t'(vec[i][1]);
        opa_select    <= opa_sel_t'(vec[i][2]);
        opb_select    <= opb_sel_t'(vec[i][3]);
        rs1           <= vec[i][4];
        rs2           <= vec[i][5];
        pc            <= vec[i][6];
        npc           <= vec[i][7];
        inst          <= vec[i][8];
        cond_branch   <= vec[i][9][0];
        uncond_branch <= vec[i][10][0];
    endtask

    // one vector per cycle while the queue has room
    task automatic issue_range(input int first, input int last);
        int idx;
        idx = first;
        while (idx < last) begin
            @(posedge clk);
            // issue_valid high in the cycle just ended was written
            if (issue_valid) begin
                exp_tag.push_back(vec[idx][0]);
                exp_value.push_back(vec[idx][11]);
                exp_br.push_back(vec[idx][12]);
                idx++;
            end
            // alu_busy will be high in the coming cycle at QUEUE_DEPTH-1
            if (idx < last && occ_next < QUEUE_DEPTH - 1) begin
                drive_vector(idx);
            end else begin
                issue_valid <= 1'b0;
                if (idx < last) begin
                    n_stalls++;
                end
            end
        end
    endtask

    ////////////////////////////////////////
    // scoreboard
    ////////////////////////////////////////
    task automatic collect_results(input int total);
        while (n_seen < total) begin
            @(posedge clk);
            if (!rst && cdb_valid) begin
                if (exp_tag.size() == 0) begin
                    n_errors++;
                    $display("record with tag %h reached the CDB but none was issued",
                             cdb_tag);
                end else begin
                    check_value("cdb_tag", exp_tag.pop_front(), 32'(cdb_tag));
                    check_value("cdb_value", exp_value.pop_front(), cdb_value);
                    check_value("cdb_take_branch", exp_br.pop_front(),
                                32'(cdb_take_branch));
                    n_seen++;
                end
            end
        end
    endtask

    // write on issue, pop when not empty and the bus is free
    assign occ_next = occ + int'(issue_valid) - int'((occ != 0) && !cdb_busy);

    // alu_busy against the expected occupancy every cycle
    always @(posedge clk) begin
        if (rst) begin
            occ <= 0;
        end else begin
            check_value("alu_busy", 32'(occ >= QUEUE_DEPTH - 1), 32'(alu_busy));
            occ <= occ_next;
        end
    end

    // cdb_busy about one cycle in three, with two windows of 8 busy cycles
    initial begin
        void'($urandom(65040));
        cdb_busy   = 1'b0;
        busy_cycle = 0;
        forever begin
            @(posedge clk);
            if (busy_mode) begin
                busy_cycle++;
                if ((busy_cycle >= 6 && busy_cycle < 14) ||
                    (busy_cycle >= 26 && busy_cycle < 34)) begin
                    cdb_busy <= 1'b1;
                end else begin
                    cdb_busy <= ($urandom_range(2) == 0);
                end
            end else begin
                cdb_busy <= 1'b0;
            end
        end
    end

    // watchdog, 20 cycles per vector plus reset
    initial begin
        wait (n_vec > 0);
        repeat (n_vec * 20 + 5) @(posedge clk);
        $display("timeout: only %0d of %0d results arrived on the CDB", n_seen, n_vec);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        clk           = 1'b0;
        rst           = 1'b1;
        issue_valid   = 1'b0;
        busy_mode     = 1'b0;
        rob_tag       = '0;
        alu_func      = '0;
        opa_select    = '0;
        opb_select    = '0;
        rs1           = '0;
        rs2           = '0;
        pc            = '0;
        npc           = '0;
        inst          = '0;
        cond_branch   = 1'b0;
        uncond_branch = 1'b0;
        n_vec         = 0;
        n_seen        = 0;
        n_stalls      = 0;
        n_checks      = 0;
        n_errors      = 0;
        read_vectors();
        if (n_vec > 0) begin
            fork
                begin
                    repeat (5) @(posedge clk);
                    rst <= 1'b0;
                    // idle after reset
                    repeat (2) @(posedge clk);
                    check_value("cdb_valid", 32'd0, 32'(cdb_valid));
                    check_value("alu_busy", 32'd0, 32'(alu_busy));
                    // single record into an empty queue, bus free
                    issue_range(0, 1);
                    @(posedge clk);
                    check_value("cdb_valid", 32'd0, 32'(cdb_valid));
                    @(posedge clk);
                    check_value("cdb_valid", 32'd1, 32'(cdb_valid));
                    busy_mode <= 1'b1;
                    issue_range(1, n_vec);
                end
                collect_results(n_vec);
            join
            busy_mode <= 1'b0;
            // any extra broadcast now is a duplicate
            repeat (4) begin
                @(posedge clk);
                check_value("cdb_valid", 32'd0, 32'(cdb_valid));
                check_value("alu_busy", 32'd0, 32'(alu_busy));
            end
            if (n_stalls == 0) begin
                n_errors++;
                $display("the issuer never stalled on alu_busy during the busy windows");
            end
        end else begin
            n_errors++;
            $display("no usable vectors were read");
        end
        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* ex_stage.f */
rtl/ex_pkg.sv
rtl/ex_result_if.sv
rtl/alu_lane.sv
rtl/result_fifo.sv
rtl/cdb_driver.sv
rtl/ex_stage.sv
dv/ex_stage_assertions.sv
dv/tb_ex_stage.sv

/* run_sim.sh */
#!/bin/sh
# build the execute stage testbench with Verilator and run it
# exit status is zero only when the run reports a pass

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_ex_stage -f ex_stage.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_ex_stage)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q "^Simulation PASSED$"; then
    exit 0
fi
exit 1

/* dv/ex_input_vectors.txt */
# tag alu_func opa_select opb_select rs1 rs2 pc npc inst cond_branch uncond_branch
# then the expected cdb_value and cdb_take_branch, every column in hex
00 0 0 0 00000005 00000003 00001000 00001004 00000000 0 0 00000008 0
01 1 0 0 00000005 00000007 00001000 00001004 00000000 0 0 fffffffe 0
02 2 0 0 f0f0f0f0 0ff00ff0 00001000 00001004 00000000 0 0 00f000f0 0
03 3 0 0 f0f0f0f0 0ff00ff0 00001000 00001004 00000000 0 0 fff0fff0 0
04 4 0 0 f0f0f0f0 0ff00ff0 00001000 00001004 00000000 0 0 ff00ff00 0
05 5 0 0 ffffffff 00000001 00001000 00001004 00000000 0 0 00000001 0
06 6 0 0 ffffffff 00000001 00001000 00001004 00000000 0 0 00000000 0
07 6 0 0 00000001 ffffffff 00001000 00001004 00000000 0 0 00000001 0
08 7 0 0 00000001 00000024 00001000 00001004 00000000 0 0 00000010 0
09 8 0 0 80000000 00000004 00001000 00001004 00000000 0 0 08000000 0
0a 9 0 0 80000000 00000004 00001000 00001004 00000000 0 0 f8000000 0
0b 0 1 0 00000000 00000010 00001000 00001004 00000000 0 0 00001014 0
0c 0 2 4 00000000 00000000 00001000 00001004 12345017 0 0 12346000 0
0d 0 3 4 00000000 00000000 00001000 00001004 fffff037 0 0 fffff000 0
0e 0 0 1 00000010 00000000 00001000 00001004 fff00093 0 0 0000000f 0
0f 0 0 1 00001000 00000000 00001000 00001004 12300093 0 0 00001123 0
10 0 0 2 00002000 00000000 00001000 00001004 fe20ae23 0 0 00001ffc 0
11 0 2 3 00000005 00000005 00001000 00001004 00208863 1 0 00001010 1
12 0 2 3 00000005 00000006 00001000 00001004 00208863 1 0 00001004 0
13 0 2 3 00000005 00000006 00001000 00001004 00209863 1 0 00001010 1
14 0 2 3 00000005 00000005 00001000 00001004 00209863 1 0 00001004 0
15 0 2 3 ffffffff 00000001 00001000 00001004 0020c863 1 0 00001010 1
16 0 2 3 00000001 ffffffff 00001000 00001004 0020c863 1 0 00001004 0
17 0 2 3 00000001 ffffffff 00001000 00001004 0020d863 1 0 00001010 1
18 0 2 3 ffffffff 00000001 00001000 00001004 0020d863 1 0 00001004 0
19 0 2 3 00000001 ffffffff 00001000 00001004 0020e863 1 0 00001010 1
1a 0 2 3 ffffffff 00000001 00001000 00001004 0020e863 1 0 00001004 0
1b 0 2 3 ffffffff 00000001 00001000 00001004 0020f863 1 0 00001010 1
1c 0 2 3 00000001 ffffffff 00001000 00001004 0020f863 1 0 00001004 0
1d 0 2 3 00000001 00000002 00004000 00004004 fe209ce3 1 0 00003ff8 1
1e 0 2 5 00000000 00000000 00002000 00002004 100000ef 0 1 00002100 1
1f 0 2 5 00000000 00000000 00003000 00003004 ffdff06f 0 1 00002ffc 1
